// File: verilog.f
src/map_pkg.sv
src/cpu_decode.sv
src/bank_regs.sv
src/addr_map.sv
src/map_243.sv
test/tb_map_243.sv

// File: run.sh
#!/bin/sh
# builds the mapper testbench with Verilator and runs it
# the full simulation output is kept in sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
	--top-module tb_map_243 \
	--Mdir obj_dir \
	-o sim_tb_map_243 \
	-f verilog.f

./obj_dir/sim_tb_map_243 > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log
then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"
exit 0

// File: test/tb_map_243.sv
module tb_map_243;

	localparam int variant    = 150;
	localparam int wait_limit = 25; // polls of two time units

	localparam int k_cpu_wr    = 0;
	localparam int k_cpu_rd    = 1;
	localparam int k_ss_wr     = 2;
	localparam int k_ss_rd     = 3;
	localparam int k_ppu       = 4;
	localparam int k_cpu_wr_ss = 5; // cpu write while the host holds ss_act
	localparam int k_rst       = 6;

	// for ppu probes, data bit 0 is chr_ram_en, bit 1 ppu_we and bit 2 ppu_oe
	typedef struct {
		int                 kind;
		map_pkg::cpu_addr_t addr;
		map_pkg::cpu_data_t data;
		map_pkg::ppu_addr_t ppu;
	} row_t;

	logic               m2;
	logic               map_rst;
	map_pkg::cpu_addr_t cpu_addr;
	map_pkg::cpu_data_t cpu_dat;
	logic               cpu_rw;
	map_pkg::ppu_addr_t ppu_addr;
	logic               ppu_oe;
	logic               ppu_we;
	logic               chr_ram_en;
	logic               ss_act;
	logic               ss_we;
	map_pkg::ss_addr_t  ss_addr;
	map_pkg::prg_addr_t prg_addr;
	map_pkg::chr_addr_t chr_addr;
	map_pkg::srm_addr_t srm_addr;
	logic               prg_oe;
	logic               chr_oe;
	logic               rom_ce;
	logic               ram_ce;
	logic               ram_we;
	logic               chr_ce;
	logic               chr_we;
	logic               ciram_a10;
	logic               ciram_ce;
	logic               map_cpu_oe;
	map_pkg::cpu_data_t map_cpu_dout;
	map_pkg::cpu_data_t ss_rdat;

	// reference model of the register file
	map_pkg::reg_val_t            model_regs [map_pkg::num_regs];
	map_pkg::reg_idx_t            model_idx;
	logic [map_pkg::num_regs-1:0] reg_known;
	logic                         idx_known;

	logic [16:0] lfsr;
	int          n_checks;
	int          n_errors;
	row_t        stim [$];

	map_243 #(.map_idx(variant)) i_dut (.*);

	// edges land on odd times only
	initial
	begin
		m2 = 1'b0;
		#5;
		forever
		begin
			m2 = 1'b1;
			#10;
			m2 = 1'b0;
			#10;
		end
	end

	function automatic map_pkg::cpu_data_t draw_byte();
		map_pkg::cpu_data_t b;
		int i;
		for (i = 0; i < 8; i++)
		begin
			lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]}; // x^17 + x^14 + 1
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	task automatic add_row(input int kind, input int addr, input int data, input int ppu);
		row_t r;
		r.kind = kind;
		r.addr = addr[15:0];
		r.data = data[7:0];
		r.ppu  = ppu[13:0];
		stim.push_back(r);
	endtask

	task automatic add_reg_write(input int idx, input int val);
		add_row(k_cpu_wr, 'h4100, idx, 0);
		add_row(k_cpu_wr, 'h4101, val, 0);
	endtask

	task automatic build_table();
		int r;
		int m;
		int q;
		for (r = 0; r < 8; r++)
			add_reg_write(r, draw_byte());
		for (r = 0; r < 8; r++)
		begin
			add_row(k_cpu_wr, 'h4100, r | 'hF8, 0); // upper data bits are dropped
			add_row(k_cpu_rd, 'h4101, 0, 0);
		end
		// ROM, RAM, the register window, its mirrors and unrelated space
		add_row(k_cpu_rd, 'h0000, 0, 0);
		add_row(k_cpu_rd, 'h2002, 0, 0);
		add_row(k_cpu_rd, 'h4016, 0, 0);
		add_row(k_cpu_rd, 'h4100, 0, 0);
		add_row(k_cpu_rd, 'h4001, 0, 0);
		add_row(k_cpu_wr, 'h4300, 3, 0);
		add_row(k_cpu_wr, 'h5D01, 6, 0);
		add_row(k_cpu_rd, 'h5F01, 0, 0);
		add_row(k_cpu_wr, 'h6101, 2, 0); // work RAM that also hits the data port
		add_row(k_cpu_wr, 'h6000, draw_byte(), 0);
		add_row(k_cpu_rd, 'h7FFF, 0, 0);
		add_row(k_cpu_wr, 'h8000, draw_byte(), 0);
		add_row(k_cpu_rd, 'hC101, 0, 0);
		add_row(k_cpu_rd, 'hFFFF, 0, 0);
		for (m = 0; m < 8; m++)
		begin
			add_reg_write(2, m);
			add_reg_write(4, m >> 1);
			add_reg_write(5, 7 - m);
			add_reg_write(6, m * 3);
			add_row(k_cpu_rd, 'h8000 + m * 'h0F13, 0, 'h0155 + m * 'h0321);
		end
		for (m = 0; m < 4; m++)
		begin
			add_reg_write(7, (m << 1) | (m & 1)); // bit 0 of r7 plays no part
			for (q = 0; q < 4; q++)
				add_row(k_ppu, 'h8000, q * 2 + 1, 'h2000 + (m & 1) * 'h1000 + q * 'h400 + 'h0A7);
		end
		for (q = 0; q < 8; q++)
			add_row(k_ppu, 'hA000, q, 'h0ABC + q * 'h111);
		for (r = 0; r <= 8; r++)
			add_row(k_ss_wr, r, draw_byte(), 0);
		add_row(k_cpu_wr_ss, 'h4100, 1, 0);
		add_row(k_cpu_wr_ss, 'h4101, 7, 0);
		for (r = 0; r <= 8; r++)
			add_row(k_ss_rd, r, 0, 0);
		add_row(k_ss_rd, 127, 0, 0);
		add_row(k_ss_rd, 9, 0, 0);
		add_row(k_ss_rd, 128, 0, 0);
		add_row(k_ss_rd, 255, 0, 0);
		add_row(k_rst, 'h0000, 0, 0);
		for (r = 0; r <= 8; r++)
			add_row(k_ss_rd, r, 0, 0);
		add_row(k_cpu_rd, 'h4101, 0, 0);
	endtask

	// polls on even times, so the clock never moves in the same step
	task automatic wait_rise();
		int steps;
		steps = 0;
		while (m2 !== 1'b0 && steps < wait_limit)
		begin
			#2;
			steps++;
		end
		while (m2 !== 1'b1 && steps < wait_limit)
		begin
			#2;
			steps++;
		end
		if (steps >= wait_limit)
		begin
			$display("timeout while waiting for a rising edge of m2");
			$display("Regression failed");
			$finish;
		end
	endtask

	task automatic drive_row(input row_t r);
		cpu_addr   = r.addr;
		cpu_dat    = r.data;
		cpu_rw     = r.kind != k_cpu_wr && r.kind != k_cpu_wr_ss;
		ppu_addr   = r.ppu;
		ppu_oe     = (r.kind == k_ppu) ? r.data[2] : 1'b1;
		ppu_we     = (r.kind == k_ppu) ? r.data[1] : 1'b1;
		chr_ram_en = (r.kind == k_ppu) ? r.data[0] : 1'b0;
		ss_act     = r.kind == k_ss_wr || r.kind == k_ss_rd || r.kind == k_cpu_wr_ss;
		ss_we      = r.kind == k_ss_wr;
		ss_addr    = r.addr[7:0];
		map_rst    = r.kind == k_rst;
	endtask

	// state after the falling edge of the cycle that carries row r
	task automatic update_model(input row_t r);
		logic in_window;
		int i;
		in_window = (r.addr & 16'hC100) == 16'h4100;
		if (r.kind == k_cpu_wr && in_window && !r.addr[0])
		begin
			model_idx = r.data[2:0];
			idx_known = 1'b1;
		end
		else if (r.kind == k_cpu_wr && in_window)
		begin
			model_regs[model_idx] = r.data[2:0];
			reg_known[model_idx]  = 1'b1;
		end
		else if (r.kind == k_ss_wr && r.addr < map_pkg::num_regs)
		begin
			model_regs[r.addr[2:0]] = r.data[2:0];
			reg_known[r.addr[2:0]]  = 1'b1;
		end
		else if (r.kind == k_ss_wr && r.addr == map_pkg::ss_slot_index)
		begin
			model_idx = r.data[2:0];
			idx_known = 1'b1;
		end
		else if (r.kind == k_rst)
		begin
			for (i = 4; i < map_pkg::num_regs; i++)
			begin
				model_regs[i] = '0;
				reg_known[i]  = 1'b1;
			end
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (act === exp)
		else
		begin
			n_errors++;
			$display("[FAIL] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_row(input row_t r);
		logic                  ram_hit;
		logic                  exp_oe;
		logic                  nt_page;
		map_pkg::prg_bank_t    prg_bank;
		map_pkg::chr_bank_t    chr_bank;
		map_pkg::cpu_data_t    exp_ss;
		ram_hit = r.addr >= 16'h6000 && r.addr <= 16'h7FFF;
		exp_oe  = cpu_rw && (r.addr & 16'hC100) == 16'h4100 && r.addr[0];
		check_val("rom_ce", r.addr >= 16'h8000, rom_ce);
		check_val("ram_ce", ram_hit, ram_ce);
		check_val("ram_we", ram_hit && !cpu_rw, ram_we);
		check_val("map_cpu_oe", exp_oe, map_cpu_oe);
		check_val("srm_addr", r.addr % 16'h2000, srm_addr);
		check_val("prg_oe", cpu_rw, prg_oe);
		check_val("chr_oe", !ppu_oe, chr_oe);
		check_val("ciram_ce", !r.ppu[13], ciram_ce); // low while in nametable space
		check_val("chr_ce", !r.ppu[13], chr_ce);
		check_val("chr_we", chr_ram_en && !ppu_we && !r.ppu[13], chr_we);
		if (&reg_known)
		begin
			prg_bank = model_regs[5][1:0];
			if (variant == 150)
				prg_bank = prg_bank | {1'b0, model_regs[2][0]};
			chr_bank = {model_regs[2][0], model_regs[4][0], model_regs[6][1:0]};
			case (model_regs[7][2:1])
				2'd0: nt_page = r.ppu[11];
				2'd1: nt_page = r.ppu[10];
				2'd2: nt_page = r.ppu[11] || r.ppu[10];
				default: nt_page = 1'b1;
			endcase
			check_val("prg_addr", {prg_bank, r.addr[14:0]}, prg_addr);
			check_val("chr_addr", {chr_bank, r.ppu[12:0]}, chr_addr);
			check_val("ciram_a10", nt_page, ciram_a10);
			if (exp_oe && idx_known)
				check_val("map_cpu_dout", model_regs[model_idx], map_cpu_dout);
		end
		if (r.kind == k_ss_wr || r.kind == k_ss_rd)
		begin
			if (r.addr < map_pkg::num_regs)
				exp_ss = {5'd0, model_regs[r.addr[2:0]]};
			else if (r.addr == map_pkg::ss_slot_index)
				exp_ss = {5'd0, model_idx};
			else if (r.addr == map_pkg::ss_slot_map_id)
				exp_ss = variant;
			else
				exp_ss = 8'hFF;
			check_val("ss_rdat", exp_ss, ss_rdat);
		end
	endtask

	initial
	begin
		row_t idle;
		int i;
		lfsr      = 17'd70481;
		n_checks  = 0;
		n_errors  = 0;
		reg_known = '0;
		idx_known = 1'b0;
		idle      = '{k_cpu_rd, 16'h0000, 8'h00, 14'h0000};
		drive_row(idle);
		map_rst = 1'b1;
		build_table();
		// reset stays high over three falling edges of m2
		for (i = 0; i < 3; i++)
			wait_rise();
		idle.kind = k_rst;
		update_model(idle);
		foreach (stim[n])
		begin
			wait_rise();
			#1;
			drive_row(stim[n]);
			update_model(stim[n]);
			#16;
			check_row(stim[n]); // just before the next rising edge
			#1;
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: src/map_243.sv
module map_243
#(
	parameter int map_idx = 243
)
(
	input  logic               m2,
	input  logic               map_rst,
	input  map_pkg::cpu_addr_t cpu_addr,
	input  map_pkg::cpu_data_t cpu_dat,
	input  logic               cpu_rw,
	input  map_pkg::ppu_addr_t ppu_addr,
	input  logic               ppu_oe,
	input  logic               ppu_we,
	input  logic               chr_ram_en,
	input  logic               ss_act,
	input  logic               ss_we,
	input  map_pkg::ss_addr_t  ss_addr,
	output map_pkg::prg_addr_t prg_addr,
	output map_pkg::chr_addr_t chr_addr,
	output map_pkg::srm_addr_t srm_addr,
	output logic               prg_oe,
	output logic               chr_oe,
	output logic               rom_ce,
	output logic               ram_ce,
	output logic               ram_we,
	output logic               chr_ce,
	output logic               chr_we,
	output logic               ciram_a10,
	output logic               ciram_ce,
	output logic               map_cpu_oe,
	output map_pkg::cpu_data_t map_cpu_dout,
	output map_pkg::cpu_data_t ss_rdat
);

	logic idx_we;
	logic dat_we;

	map_pkg::prg_bank_t    prg_bank;
	map_pkg::chr_bank_t    chr_bank;
	map_pkg::mirror_mode_t mirror_mode;

	assign srm_addr = cpu_addr[12:0]; // work RAM is never banked
	assign prg_oe   = cpu_rw;
	assign chr_oe   = !ppu_oe;

	cpu_decode i_cpu_decode
	(
		.cpu_addr   (cpu_addr),
		.cpu_rw     (cpu_rw),
		.rom_ce     (rom_ce),
		.ram_ce     (ram_ce),
		.ram_we     (ram_we),
		.idx_we     (idx_we),
		.dat_we     (dat_we),
		.map_cpu_oe (map_cpu_oe)
	);

	bank_regs #(.map_idx(map_idx)) i_bank_regs
	(
		.m2           (m2),
		.map_rst      (map_rst),
		.idx_we       (idx_we),
		.dat_we       (dat_we),
		.cpu_dat      (cpu_dat),
		.ss_act       (ss_act),
		.ss_we        (ss_we),
		.ss_addr      (ss_addr),
		.map_cpu_dout (map_cpu_dout),
		.ss_rdat      (ss_rdat),
		.prg_bank     (prg_bank),
		.chr_bank     (chr_bank),
		.mirror_mode  (mirror_mode)
	);

	addr_map i_addr_map
	(
		.cpu_addr    (cpu_addr),
		.ppu_addr    (ppu_addr),
		.ppu_we      (ppu_we),
		.chr_ram_en  (chr_ram_en),
		.prg_bank    (prg_bank),
		.chr_bank    (chr_bank),
		.mirror_mode (mirror_mode),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we)
	);

endmodule

// File: src/addr_map.sv
module addr_map
(
	input  map_pkg::cpu_addr_t    cpu_addr,
	input  map_pkg::ppu_addr_t    ppu_addr,
	input  logic                  ppu_we,
	input  logic                  chr_ram_en,
	input  map_pkg::prg_bank_t    prg_bank,
	input  map_pkg::chr_bank_t    chr_bank,
	input  map_pkg::mirror_mode_t mirror_mode,
	output map_pkg::prg_addr_t    prg_addr,
	output map_pkg::chr_addr_t    chr_addr,
	output logic                  ciram_a10,
	output logic                  ciram_ce,
	output logic                  chr_ce,
	output logic                  chr_we
);

	// 32K PRG window at 8000, bank on the two top lines
	assign prg_addr = {prg_bank, cpu_addr[14:0]};

	// 8K CHR window covering the whole pattern table space
	assign chr_addr = {chr_bank, ppu_addr[12:0]};

	// A13 high means nametable space, which goes to the console's own VRAM
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce   = ciram_ce; // CHR is only selected below 2000

	// CHR RAM boards take PPU writes in pattern space, ppu_we is low-true
	assign chr_we = chr_ram_en & !ppu_we & ciram_ce;

	// nametable mirroring
	always_comb
	begin
		case (mirror_mode)
			2'd0:
				ciram_a10 = ppu_addr[11]; // horizontal
			2'd1:
				ciram_a10 = ppu_addr[10]; // vertical
			2'd2:
				// L-shaped, only the first nametable uses page 0
				ciram_a10 = ppu_addr[11:10] != 2'd0;
			default:
				ciram_a10 = 1'b1; // single screen, upper page
		endcase
	end

	// a CHR RAM write always has the CHR chip selected
	always_comb
	begin
		assert (!chr_we || chr_ce)
		else $error("chr_we active without chr_ce at %h", ppu_addr);
	end

endmodule

// File: src/bank_regs.sv
module bank_regs
#(
	parameter int map_idx = 243
)
(
	input  logic                  m2,
	input  logic                  map_rst,
	input  logic                  idx_we,
	input  logic                  dat_we,
	input  map_pkg::cpu_data_t    cpu_dat,
	input  logic                  ss_act,
	input  logic                  ss_we,
	input  map_pkg::ss_addr_t     ss_addr,
	output map_pkg::cpu_data_t    map_cpu_dout,
	output map_pkg::cpu_data_t    ss_rdat,
	output map_pkg::prg_bank_t    prg_bank,
	output map_pkg::chr_bank_t    chr_bank,
	output map_pkg::mirror_mode_t mirror_mode
);

	// board 150 also routes register 2 bit 0 onto the PRG bank
	localparam bit prg_or_r2 = (map_idx == 150);

	map_pkg::reg_idx_t reg_idx;
	map_pkg::reg_val_t regs [map_pkg::num_regs];

	logic ss_reg_hit;
	logic ss_idx_hit;
	map_pkg::reg_idx_t ss_sel;

	assign ss_reg_hit = ss_addr < map_pkg::num_regs;
	assign ss_idx_hit = ss_addr == map_pkg::ss_slot_index;
	assign ss_sel     = map_pkg::reg_idx_t'(ss_addr); // low bits pick the register

	// everything moves on the falling edge of m2, once the cpu data is stable
	always_ff @(negedge m2)
	begin
		if (ss_act)
		begin
			// host owns the registers while a state is saved or restored
			if (ss_we && ss_reg_hit)
				regs[ss_sel] <= cpu_dat[2:0];
			if (ss_we && ss_idx_hit)
				reg_idx <= cpu_dat[2:0];
		end
		else if (map_rst)
		begin
			regs[4] <= '0; // 0 to 3 and the index survive a console reset
			regs[5] <= '0;
			regs[6] <= '0;
			regs[7] <= '0;
		end
		else
		begin
			if (idx_we)
				reg_idx <= cpu_dat[2:0];
			if (dat_we)
				regs[reg_idx] <= cpu_dat[2:0];
		end
	end

	assign map_cpu_dout = {5'd0, regs[reg_idx]};

	// save-state readback
	always_comb
	begin
		if (ss_reg_hit)
			ss_rdat = {5'd0, regs[ss_sel]};
		else if (ss_idx_hit)
			ss_rdat = {5'd0, reg_idx};
		else if (ss_addr == map_pkg::ss_slot_map_id)
			ss_rdat = map_pkg::cpu_data_t'(map_idx);
		else
			ss_rdat = 8'hFF; // unused slots
	end

	// bank numbers for the address builder
	always_comb
	begin
		chr_bank    = {regs[2][0], regs[4][0], regs[6][1:0]};
		mirror_mode = regs[7][2:1];
		prg_bank    = regs[5][1:0];
		if (prg_or_r2)
			prg_bank = prg_bank | {1'b0, regs[2][0]};
	end

	// the host port drives ss_we only inside an active save-state window
	assert property (@(negedge m2) ss_we |-> ss_act)
	else $error("save-state write with ss_act low");

endmodule

// File: src/cpu_decode.sv
module cpu_decode
(
	input  map_pkg::cpu_addr_t cpu_addr,
	input  logic               cpu_rw,
	output logic               rom_ce,
	output logic               ram_ce,
	output logic               ram_we,
	output logic               idx_we,
	output logic               dat_we,
	output logic               map_cpu_oe
);

	// the register window repeats wherever A15, A14 and A8 match 0, 1, 1
	localparam map_pkg::cpu_addr_t reg_win_mask  = 16'hC100;
	localparam map_pkg::cpu_addr_t reg_win_match = 16'h4100;

	logic regs_ce;
	logic cpu_wr;

	assign cpu_wr  = !cpu_rw; // rw is high for a read
	assign regs_ce = (cpu_addr & reg_win_mask) == reg_win_match;

	assign rom_ce = cpu_addr[15];               // 8000-FFFF
	assign ram_ce = cpu_addr[15:13] == 3'b011;  // 6000-7FFF
	assign ram_we = ram_ce & cpu_wr;

	// A0 splits the window into the index port and the data port
	always_comb
	begin
		idx_we     = regs_ce & cpu_wr & !cpu_addr[0];
		dat_we     = regs_ce & cpu_wr & cpu_addr[0];
		map_cpu_oe = regs_ce & cpu_rw & cpu_addr[0]; // only the data port reads back
	end

	// the enables feed separate chips, so an overlap would drive the data bus twice
	always_comb
	begin
		assert (!(rom_ce && ram_ce))
		else $error("rom_ce and ram_ce both active at %h", cpu_addr);
	end

	// a single bus cycle never hits both ports
	always_comb
	begin
		assert (!(idx_we && dat_we))
		else $error("idx_we and dat_we both active at %h", cpu_addr);
	end

endmodule

// File: src/map_pkg.sv
package map_pkg;

	// cpu side buses
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// ppu side bus
	typedef logic [13:0] ppu_addr_t;

	// cartridge memory addresses
	typedef logic [16:0] prg_addr_t; // 128K of PRG ROM
	typedef logic [16:0] chr_addr_t; // 128K of CHR
	typedef logic [12:0] srm_addr_t; // 8K of work RAM

	// host side save-state slot number
	typedef logic [7:0] ss_addr_t;

	// the mapper only keeps three bits per register
	typedef logic [2:0] reg_val_t;
	typedef logic [2:0] reg_idx_t;

	// bank numbers that land on the upper address lines
	typedef logic [1:0] prg_bank_t;  // selects a 32K PRG window
	typedef logic [3:0] chr_bank_t;  // selects an 8K CHR window
	typedef logic [1:0] mirror_mode_t;

	// size of the indexed register file
	localparam int num_regs = 8;

	// slots 0 to 7 map straight onto the registers
	localparam ss_addr_t ss_slot_index  = 8'd8;   // index register
	localparam ss_addr_t ss_slot_map_id = 8'd127; // read-only board number

endpackage
